// ==== coco_io_pkg.sv ====
`default_nettype none

package coco_io_pkg;

	////////////////////
	// Widths
	////////////////////
	localparam int ADC_W     = 12;	// ADC conversion result
	localparam int DAC_W     = 12;	// Core DAC sound level
	localparam int AUDIO_W   = 16;	// Output audio sample
	localparam int JOY_BTN_W = 32;	// Digital stick bits
	localparam int AXIS_W    = 8;	// One analog axis
	localparam int RST_CNT_W = 4;	// Reset countdown

	typedef logic [ADC_W-1:0]     adc_value_t;
	typedef logic [DAC_W-1:0]     dac_sound_t;
	typedef logic [AUDIO_W-1:0]   audio_word_t;
	typedef logic [JOY_BTN_W-1:0] joy_buttons_t;
	typedef logic [AXIS_W-1:0]    axis_t;
	typedef logic [RST_CNT_W-1:0] reset_count_t;

	// One converter sample, offered for a single cycle
	typedef struct packed {
		logic       valid;
		adc_value_t value;
	} adc_sample_t;

	typedef struct packed {
		joy_buttons_t buttons;
		axis_t        x;	// Signed in, offset binary out
		axis_t        y;
	} joystick_t;

	// Code 3 unused, decodes like a Dragon 32
	typedef enum logic [1:0] {
		MACH_COCO2    = 2'd0,
		MACH_DRAGON32 = 2'd1,
		MACH_DRAGON64 = 2'd2
	} machine_t;

	typedef struct packed {
		logic dragon;
		logic dragon64;
		logic disk_en;
	} machine_flags_t;

	// Axis midpoint, added mod 256 to center a signed axis
	localparam axis_t AXIS_MID = axis_t'(1 << (AXIS_W - 1));

	////////////////////
	// Parameter defaults
	////////////////////
	localparam int AVG_DEPTH_DEF    = 512;	// Power of two
	localparam int SLICE_THRESH_DEF = 100;	// ADC codes either side of average
	localparam int RESET_CYCLES_DEF = 15;	// Must fit reset_count_t

endpackage

`default_nettype wire

// ==== adc_cassette_slicer.sv ====
`default_nettype none

module adc_cassette_slicer
	import coco_io_pkg::*;
#(
	parameter int AVG_DEPTH    = AVG_DEPTH_DEF,
	parameter int SLICE_THRESH = SLICE_THRESH_DEF
)
(
	input  wire         clk_sys,
	input  wire         i_rst,
	input  wire adc_sample_t i_adc,	// One sample per valid cycle, no stall
	output logic        o_cas_bit
);

	localparam int PTR_W = $clog2(AVG_DEPTH);
	localparam int SUM_W = ADC_W + PTR_W;	// Room for AVG_DEPTH full-scale codes
	localparam logic [SUM_W-1:0] MAX_TOTAL = SUM_W'(AVG_DEPTH * ((1 << ADC_W) - 1));

	////////////////////
	// History ring
	////////////////////
	adc_value_t       hist_mem [AVG_DEPTH];	// Sample payload, no reset
	logic [PTR_W-1:0] wr_ptr;		// Also points at the oldest entry
	logic [PTR_W:0]   fill_cnt;		// Samples seen, saturates at AVG_DEPTH
	logic             hist_full;
	adc_value_t       oldest;

	assign hist_full = fill_cnt[PTR_W];
	// Slots not yet written count as zero
	assign oldest    = hist_full ? hist_mem[wr_ptr] : '0;

	always_ff @(posedge clk_sys)
	begin
		if (i_adc.valid)
			hist_mem[wr_ptr] <= i_adc.value;	// Overwrite oldest
	end

	////////////////////
	// Average and slicer
	////////////////////
	logic [SUM_W-1:0] total;	// Sum of the last AVG_DEPTH samples
	adc_value_t       avg;
	logic             below;
	logic             above;

	assign avg = adc_value_t'(total >> PTR_W);	// Floor of total / AVG_DEPTH

	// Signed compare so avg - thresh never wraps
	assign below = int'(i_adc.value) < (int'(avg) - SLICE_THRESH);
	assign above = int'(i_adc.value) > (int'(avg) + SLICE_THRESH);

	always_ff @(posedge clk_sys)
	begin
		if (i_rst)
		begin
			wr_ptr    <= '0;
			fill_cnt  <= '0;
			total     <= '0;
			o_cas_bit <= 1'b0;
		end
		else if (i_adc.valid)
		begin
			// Low swing sets the bit, polarity inverted as on the real machine
			if (below)
				o_cas_bit <= 1'b1;
			else if (above)
				o_cas_bit <= 1'b0;
			// Inside the band the bit holds

			total  <= total + SUM_W'(i_adc.value) - SUM_W'(oldest);	// Slide window
			wr_ptr <= wr_ptr + 1'b1;	// Wraps at AVG_DEPTH
			if (!hist_full)
				fill_cnt <= fill_cnt + 1'b1;
		end
	end

	// Window sum stays within full scale times depth
	a_total_bound: assert property (@(posedge clk_sys) disable iff (i_rst)
		total <= MAX_TOTAL);

	// Bit only moves right after a sample was taken
	a_bit_after_valid: assert property (@(posedge clk_sys) disable iff (i_rst)
		(!$past(i_rst) && !$stable(o_cas_bit)) |-> $past(i_adc.valid));

endmodule

`default_nettype wire

// ==== machine_reset_ctrl.sv ====
`default_nettype none

module machine_reset_ctrl
	import coco_io_pkg::*;
#(
	parameter int RESET_CYCLES = RESET_CYCLES_DEF
)
(
	input  wire            clk_sys,
	input  wire            i_rst,
	input  wire machine_t  i_machine,
	input  wire            i_disk_sel,	// Disk cartridge instead of ROM cart
	input  wire            i_hard_req,	// Menu hard-reset bit, any toggle counts
	input  wire            i_user_rst,
	output machine_flags_t o_flags,
	output logic           o_sys_rst,
	output logic           o_hard_rst
);

	localparam reset_count_t RESET_LOAD = reset_count_t'(RESET_CYCLES);

	machine_t     machine_q;	// Settings seen last cycle
	logic         disk_q;
	logic         hreq_q;
	logic         change;
	reset_count_t rst_cnt;	// Cycles of system reset left

	// Any difference against the stored copy restarts the sequence
	assign change = (i_machine != machine_q) ||
	                (i_disk_sel != disk_q) ||
	                (i_hard_req != hreq_q);

	assign o_sys_rst = (rst_cnt != '0) | i_user_rst;	// User reset passes straight through

	////////////////////
	// Change detect and countdown
	////////////////////
	always_ff @(posedge clk_sys)
	begin
		if (i_rst)
		begin
			machine_q  <= MACH_COCO2;
			disk_q     <= 1'b0;
			hreq_q     <= 1'b0;
			rst_cnt    <= '0;
			o_hard_rst <= 1'b0;
			o_flags    <= '0;
		end
		else
		begin
			machine_q <= i_machine;
			disk_q    <= i_disk_sel;
			hreq_q    <= i_hard_req;

			if (change)
				rst_cnt <= RESET_LOAD;	// Reload even mid-countdown
			else if (rst_cnt != '0)
				rst_cnt <= rst_cnt - 1'b1;

			// Only the first cycle of a fresh reset window
			o_hard_rst <= change & (rst_cnt == '0);

			// Flag decode, code 3 behaves as a Dragon 32
			o_flags.dragon   <= (i_machine != MACH_COCO2);
			o_flags.dragon64 <= (i_machine == MACH_DRAGON64);
			o_flags.disk_en  <= i_disk_sel;
		end
	end

	a_hard_one_cycle: assert property (@(posedge clk_sys) disable iff (i_rst)
		o_hard_rst |=> !o_hard_rst);

endmodule

`default_nettype wire

// ==== joystick_router.sv ====
`default_nettype none

module joystick_router
	import coco_io_pkg::*;
(
	input  wire            clk_sys,
	input  wire            i_rst,
	input  wire joystick_t i_joy_a,
	input  wire joystick_t i_joy_b,
	input  wire            i_swap,	// Exchange the two ports
	output joystick_t      o_joy_1,
	output joystick_t      o_joy_2
);

	// Signed axis to offset binary, buttons untouched
	function automatic joystick_t center_axes(input joystick_t j);
		joystick_t r;
		r   = j;
		r.x = j.x + AXIS_MID;	// Mod 256, flips the top bit
		r.y = j.y + AXIS_MID;
		return r;
	endfunction

	joystick_t sel_1;
	joystick_t sel_2;

	assign sel_1 = i_swap ? i_joy_b : i_joy_a;
	assign sel_2 = i_swap ? i_joy_a : i_joy_b;

	always_ff @(posedge clk_sys)
	begin
		if (i_rst)
		begin
			o_joy_1 <= '0;
			o_joy_2 <= '0;
		end
		else
		begin
			o_joy_1 <= center_axes(sel_1);
			o_joy_2 <= center_axes(sel_2);
		end
	end

endmodule

`default_nettype wire

// ==== cassette_audio_mixer.sv ====
`default_nettype none

module cassette_audio_mixer
	import coco_io_pkg::*;
(
	input  wire             clk_sys,
	input  wire             i_rst,
	input  wire             i_beep,		// 1-bit sound, loudest
	input  wire dac_sound_t i_dac,
	input  wire             i_monitor,	// Mix tape bit into audio
	input  wire             i_src_adc,	// Tape from ADC slicer, else file
	input  wire             i_adc_bit,
	input  wire             i_file_bit,
	output audio_word_t     o_audio,
	output logic            o_cas_in	// Tape bit into the core
);

	logic tape_bit;

	assign tape_bit = i_src_adc ? i_adc_bit : i_file_bit;

	always_ff @(posedge clk_sys)
	begin
		if (i_rst)
		begin
			o_audio  <= '0;
			o_cas_in <= 1'b0;
		end
		else
		begin
			o_cas_in <= tape_bit;
			// Beeper, DAC top, DAC bit 5 with tape folded in, DAC low, pad
			o_audio  <= {i_beep, i_dac[11:6], i_dac[5] ^ (i_monitor & tape_bit),
			             i_dac[4:0], 3'b000};
		end
	end

	a_beep_msb: assert property (@(posedge clk_sys) disable iff (i_rst)
		!$past(i_rst) |-> (o_audio[AUDIO_W-1] == $past(i_beep)));

endmodule

`default_nettype wire

// ==== coco_io_top.sv ====
`default_nettype none

module coco_io_top
	import coco_io_pkg::*;
#(
	parameter int AVG_DEPTH    = AVG_DEPTH_DEF,
	parameter int SLICE_THRESH = SLICE_THRESH_DEF,
	parameter int RESET_CYCLES = RESET_CYCLES_DEF
)
(
	input  wire              clk_sys,
	input  wire              i_rst,
	// Cassette ADC
	input  wire adc_sample_t i_adc,
	// Machine settings
	input  wire machine_t    i_machine,
	input  wire              i_disk_sel,
	input  wire              i_hard_req,
	input  wire              i_user_rst,
	output machine_flags_t   o_flags,
	output logic             o_sys_rst,
	output logic             o_hard_rst,
	// Joysticks
	input  wire joystick_t   i_joy_a,
	input  wire joystick_t   i_joy_b,
	input  wire              i_swap,
	output joystick_t        o_joy_1,
	output joystick_t        o_joy_2,
	// Audio and tape
	input  wire              i_beep,
	input  wire dac_sound_t  i_dac,
	input  wire              i_monitor,
	input  wire              i_src_adc,
	input  wire              i_file_bit,
	output audio_word_t      o_audio,
	output logic             o_cas_in
);

	logic adc_bit;	// Sliced tape bit from the ADC path

	adc_cassette_slicer #(.AVG_DEPTH(AVG_DEPTH), .SLICE_THRESH(SLICE_THRESH)) u_slicer
	(
		.clk_sys   (clk_sys),
		.i_rst     (i_rst),
		.i_adc     (i_adc),
		.o_cas_bit (adc_bit)
	);

	machine_reset_ctrl #(.RESET_CYCLES(RESET_CYCLES)) u_reset_ctrl
	(
		.clk_sys    (clk_sys),
		.i_rst      (i_rst),
		.i_machine  (i_machine),
		.i_disk_sel (i_disk_sel),
		.i_hard_req (i_hard_req),
		.i_user_rst (i_user_rst),
		.o_flags    (o_flags),
		.o_sys_rst  (o_sys_rst),
		.o_hard_rst (o_hard_rst)
	);

	joystick_router u_joy_router
	(
		.clk_sys (clk_sys),
		.i_rst   (i_rst),
		.i_joy_a (i_joy_a),
		.i_joy_b (i_joy_b),
		.i_swap  (i_swap),
		.o_joy_1 (o_joy_1),
		.o_joy_2 (o_joy_2)
	);

	cassette_audio_mixer u_audio_mixer
	(
		.clk_sys    (clk_sys),
		.i_rst      (i_rst),
		.i_beep     (i_beep),
		.i_dac      (i_dac),
		.i_monitor  (i_monitor),
		.i_src_adc  (i_src_adc),
		.i_adc_bit  (adc_bit),
		.i_file_bit (i_file_bit),
		.o_audio    (o_audio),
		.o_cas_in   (o_cas_in)
	);

endmodule

`default_nettype wire

// ==== tb_coco_io.sv ====
`default_nettype none

module tb_coco_io
	import coco_io_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int AVG_DEPTH    = 16;
	localparam int SLICE_THRESH = 100;
	localparam int RESET_CYCLES = 15;
	localparam int N_ADC        = 80;	// Slicer rows, gaps included
	localparam int N_RST        = 6;
	localparam int N_JOY        = 8;
	localparam int N_AUD        = 12;
	localparam int WATCHDOG_CYC = (N_ADC + N_RST + N_JOY + N_AUD + 1) * 20 + 200;

	typedef struct packed {
		adc_sample_t smp;
		logic        exp_bit;	// Slicer bit once this row is taken
	} adc_row_t;

	typedef struct packed {
		machine_t       machine;
		logic           disk;
		logic           hreq;
		machine_flags_t exp_flags;
	} rst_row_t;

	typedef struct packed {
		joystick_t a;
		joystick_t b;
		logic      swap;
		joystick_t exp_1;
		joystick_t exp_2;
	} joy_row_t;

	typedef struct packed {
		logic        beep;
		dac_sound_t  dac;
		logic        monitor;
		logic        src_adc;
		logic        file_bit;
		audio_word_t exp_audio;
		logic        exp_cas;
	} aud_row_t;

	logic           clk_sys;
	logic           i_rst;
	adc_sample_t    i_adc;
	machine_t       i_machine;
	logic           i_disk_sel, i_hard_req, i_user_rst;
	machine_flags_t o_flags;
	logic           o_sys_rst, o_hard_rst;
	joystick_t      i_joy_a, i_joy_b, o_joy_1, o_joy_2;
	logic           i_swap;
	logic           i_beep, i_monitor, i_src_adc, i_file_bit;
	dac_sound_t     i_dac;
	audio_word_t    o_audio;
	logic           o_cas_in;

	adc_row_t adc_tab [N_ADC];
	rst_row_t rst_tab [N_RST];
	joy_row_t joy_tab [N_JOY];
	aud_row_t aud_tab [N_AUD];
	integer   seed = 84282;
	logic     cas_pipe [$];	// Expected o_cas_in, two edges behind i_adc

	coco_io_top #(.AVG_DEPTH(AVG_DEPTH), .SLICE_THRESH(SLICE_THRESH), .RESET_CYCLES(RESET_CYCLES))
		i_coco_io_top (.*);

	initial
	begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;	// 8 ns period
	end

	initial
	begin
		repeat (WATCHDOG_CYC) @(posedge clk_sys);
		fail_run("Timeout: the test sequence did not finish within the watchdog limit");
	end

	////////////////////
	// Failure and compare
	////////////////////
	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input string exp, input string act);
		fail_run($sformatf("CHECK FAILED at %0.1f ns: %s expected %s, actual %s",
			$realtime, name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			report_mismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
	endtask

	task automatic check_audio(input string name, input audio_word_t exp, input audio_word_t act);
		if (act !== exp)
			report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
	endtask

	task automatic check_joy(input string name, input joystick_t exp, input joystick_t act);
		if (act !== exp)
			report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
	endtask

	task automatic check_flags(input string name, input machine_flags_t exp,
		input machine_flags_t act);
		if (act !== exp)
			report_mismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
	endtask

	task automatic step_cycle();
		@(posedge clk_sys);
		#1;	// Drive and sample just past the edge
	endtask

	////////////////////
	// Reference models
	////////////////////
	function automatic machine_flags_t decode_flags(input machine_t m, input logic disk);
		machine_flags_t f;
		f.disk_en = disk;
		case (m)
			MACH_COCO2:    {f.dragon, f.dragon64} = 2'b00;
			MACH_DRAGON64: {f.dragon, f.dragon64} = 2'b11;
			default:       {f.dragon, f.dragon64} = 2'b10;	// Dragon 32 and spare code
		endcase
		return f;
	endfunction

	function automatic joystick_t offset_axes(input joystick_t j);
		joystick_t r;
		r      = j;
		r.x[7] = ~j.x[7];	// +128 mod 256
		r.y[7] = ~j.y[7];
		return r;
	endfunction

	function automatic audio_word_t build_audio(input logic beep, input dac_sound_t dac,
		input logic monitor, input logic tape);
		audio_word_t w;
		w       = '0;
		w[15]   = beep;
		w[14:3] = dac;	// Low three bits stay zero
		if (monitor)
			w[8] = w[8] ^ tape;	// DAC bit 5 sits at word bit 8
		return w;
	endfunction

	task automatic build_tables();
		int          hist [AVG_DEPTH];
		int          hp;
		int          sum;
		int          lvl;
		logic        bit_st;
		logic [31:0] r;
		hist   = '{default: 0};	// Missing history counts as zero
		hp     = 0;
		bit_st = 1'b0;
		for (int k = 0; k < N_ADC; k++)
		begin
			case (k % 10)
				0, 3:    lvl = 0;	// Gap rows, value must be ignored
				5:       lvl = 2048 + 300;
				8:       lvl = 2048 - 300;
				default: lvl = 2048;
			endcase
			lvl = lvl + $random(seed) % 41;	// Noise well inside the band
			adc_tab[k].smp.valid = (k % 10 != 0) && (k % 10 != 3);
			adc_tab[k].smp.value = adc_value_t'(lvl);
			if (adc_tab[k].smp.valid)
			begin
				sum = 0;
				foreach (hist[i])
					sum += hist[i];
				if (lvl < sum / AVG_DEPTH - SLICE_THRESH)
					bit_st = 1'b1;	// Low swing
				else if (lvl > sum / AVG_DEPTH + SLICE_THRESH)
					bit_st = 1'b0;
				hist[hp] = lvl;
				hp       = (hp + 1) % AVG_DEPTH;
			end
			adc_tab[k].exp_bit = bit_st;
		end
		rst_tab[0] = '{MACH_DRAGON32, 1'b0, 1'b0, '0};
		rst_tab[1] = '{MACH_DRAGON64, 1'b0, 1'b0, '0};
		rst_tab[2] = '{MACH_DRAGON64, 1'b1, 1'b0, '0};	// Disk cart only
		rst_tab[3] = '{MACH_COCO2, 1'b1, 1'b0, '0};
		rst_tab[4] = '{MACH_COCO2, 1'b1, 1'b1, '0};	// Menu hard reset only
		rst_tab[5] = '{machine_t'(2'd3), 1'b0, 1'b1, '0};
		foreach (rst_tab[k])
			rst_tab[k].exp_flags = decode_flags(rst_tab[k].machine, rst_tab[k].disk);
		for (int k = 0; k < N_JOY; k++)
		begin
			joy_tab[k].a     = joystick_t'({$random(seed), $random(seed)});
			joy_tab[k].b     = joystick_t'({$random(seed), $random(seed)});
			joy_tab[k].swap  = k[0];
			joy_tab[k].exp_1 = offset_axes(k[0] ? joy_tab[k].b : joy_tab[k].a);
			joy_tab[k].exp_2 = offset_axes(k[0] ? joy_tab[k].a : joy_tab[k].b);
		end
		for (int k = 0; k < N_AUD; k++)
		begin
			r = $random(seed);
			aud_tab[k].beep     = r[0];
			aud_tab[k].monitor  = r[1];
			aud_tab[k].src_adc  = r[2];
			aud_tab[k].file_bit = r[3];
			aud_tab[k].dac      = r[31:20];
			// Slicer holds its last bit, no samples in this section
			aud_tab[k].exp_cas   = r[2] ? adc_tab[N_ADC-1].exp_bit : r[3];
			aud_tab[k].exp_audio = build_audio(r[0], r[31:20], r[1], aud_tab[k].exp_cas);
		end
	endtask

	////////////////////
	// Test sequence
	////////////////////
	initial
	begin
		i_rst      = 1'b1;
		i_adc      = '0;
		i_machine  = MACH_COCO2;	// Matches the reset copy, no startup sequence
		i_disk_sel = 1'b0;
		i_hard_req = 1'b0;
		i_user_rst = 1'b0;
		i_joy_a    = '0;
		i_joy_b    = '0;
		i_swap     = 1'b0;
		i_beep     = 1'b0;
		i_dac      = '0;
		i_monitor  = 1'b0;
		i_src_adc  = 1'b1;	// Slicer bit onto o_cas_in
		i_file_bit = 1'b0;
		build_tables();
		repeat (10) @(posedge clk_sys);
		#1;
		i_rst = 1'b0;

		// Slicer, seen through the mixer register
		cas_pipe = '{1'b0, 1'b0};
		for (int k = 0; k < N_ADC; k++)
		begin
			i_adc = adc_tab[k].smp;
			check_bit("o_cas_in", cas_pipe.pop_front(), o_cas_in);
			cas_pipe.push_back(adc_tab[k].exp_bit);
			step_cycle();
		end
		i_adc = '0;
		while (cas_pipe.size() > 0)
		begin
			check_bit("o_cas_in", cas_pipe.pop_front(), o_cas_in);
			step_cycle();
		end

		// Settings changes, one full reset window each
		check_bit("o_sys_rst", 1'b0, o_sys_rst);
		for (int k = 0; k < N_RST; k++)
		begin
			i_machine  = rst_tab[k].machine;
			i_disk_sel = rst_tab[k].disk;
			i_hard_req = rst_tab[k].hreq;
			for (int c = 0; c <= RESET_CYCLES; c++)
			begin
				step_cycle();
				check_bit("o_sys_rst", c < RESET_CYCLES, o_sys_rst);
				check_bit("o_hard_rst", c == 0, o_hard_rst);	// First cycle only
				check_flags("o_flags", rst_tab[k].exp_flags, o_flags);
			end
		end

		// User reset is combinational
		i_user_rst = 1'b1;
		#1;
		check_bit("o_sys_rst", 1'b1, o_sys_rst);
		check_bit("o_hard_rst", 1'b0, o_hard_rst);
		step_cycle();
		check_bit("o_hard_rst", 1'b0, o_hard_rst);
		i_user_rst = 1'b0;
		#1;
		check_bit("o_sys_rst", 1'b0, o_sys_rst);
		step_cycle();

		for (int k = 0; k < N_JOY; k++)
		begin
			i_joy_a = joy_tab[k].a;
			i_joy_b = joy_tab[k].b;
			i_swap  = joy_tab[k].swap;
			step_cycle();
			check_joy("o_joy_1", joy_tab[k].exp_1, o_joy_1);
			check_joy("o_joy_2", joy_tab[k].exp_2, o_joy_2);
		end

		for (int k = 0; k < N_AUD; k++)
		begin
			i_beep     = aud_tab[k].beep;
			i_dac      = aud_tab[k].dac;
			i_monitor  = aud_tab[k].monitor;
			i_src_adc  = aud_tab[k].src_adc;
			i_file_bit = aud_tab[k].file_bit;
			step_cycle();
			check_audio("o_audio", aud_tab[k].exp_audio, o_audio);
			check_bit("o_cas_in", aud_tab[k].exp_cas, o_cas_in);
		end

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
coco_io_pkg.sv
adc_cassette_slicer.sv
machine_reset_ctrl.sv
joystick_router.sv
cassette_audio_mixer.sv
coco_io_top.sv
tb_coco_io.sv
